// File: gpuPkg.sv
/*
  Shared sizes and types of the fill engine.
  The frame is a flat array of FrameWords pixels in raster order.
  FifoDepth must be a power of two.
*/
package gpuPkg;

    localparam int HDisp      = 64;
    localparam int VDisp      = 48;
    localparam int FrameWords = HDisp * VDisp;

    // Write buffer entries and pointer width
    localparam int FifoDepth  = 4;
    localparam int FifoAddrW  = $clog2(FifoDepth);

    typedef logic [15:0] coordT;
    typedef logic [23:0] pixelT;
    typedef logic [23:0] lenT;
    typedef logic [31:0] sysAddrT;
    typedef logic [11:0] memAddrT;

    // Fill controller states
    typedef enum logic [2:0] {
        Idle,
        Load,
        Write,
        Flush,
        Done
    } fillStateT;

endpackage

// File: frameMemory.sv
/*
  On-chip frame store in place of SDRAM. One write port, one read port
  with a registered output. Contents are undefined until written, and
  reads above FrameWords-1 return undefined data.
*/
`timescale 1ns/1ps

module frameMemory import gpuPkg::*; (
    input  logic    clk,
    input  logic    wrEn,
    input  memAddrT wrAddr,
    input  pixelT   wrData,
    input  memAddrT rdAddr,
    output pixelT   rdData
);

    pixelT mem [FrameWords];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // One cycle read latency
    always_ff @(posedge clk) begin
        rdData <= mem[rdAddr];
    end

endmodule

// File: frameWriteBuffer.sv
/*
  Write buffer between the fill controller and frame memory.
  Addresses are assigned as words arrive, starting at sysAddrMin and
  wrapping to zero at sysAddrMax. A word sent with sysLoad uses the new
  start. Memory writes go out at most once every second cycle.
*/
`timescale 1ns/1ps

module frameWriteBuffer import gpuPkg::*; (
    input  logic    clk,
    input  logic    rstn,
    input  logic    sysLoad,
    input  sysAddrT sysAddrMin,
    input  sysAddrT sysAddrMax,
    input  logic    sysWriteEnable,
    input  pixelT   sysData,
    output logic    sysValid,
    output logic    sysIdle,
    output logic    wrEn,
    output memAddrT wrAddr,
    output pixelT   wrData
);

    memAddrT addrMem [FifoDepth];
    pixelT   dataMem [FifoDepth];

    logic [FifoAddrW-1:0] wrPtr;
    logic [FifoAddrW-1:0] rdPtr;
    logic [FifoAddrW:0]   count;

    sysAddrT nextAddr;
    sysAddrT curAddr;
    sysAddrT incAddr;
    logic    pace;
    logic    push;
    logic    pop;

    assign sysValid = (count != FifoDepth);
    assign sysIdle  = (count == '0) && !wrEn;

    assign push = sysWriteEnable && sysValid;
    assign pop  = pace && (count != '0);

    // A load in the same cycle as a word takes effect for that word
    assign curAddr = sysLoad ? sysAddrMin : nextAddr;
    assign incAddr = curAddr + 1'b1;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            count    <= '0;
            nextAddr <= '0;
            pace     <= 1'b0;
            wrEn     <= 1'b0;
        end else begin
            // Memory side runs at half rate
            pace <= ~pace;
            wrEn <= pop;

            if (push) begin
                wrPtr <= wrPtr + 1'b1;
                if (incAddr >= sysAddrMax) begin
                    nextAddr <= '0;
                end else begin
                    nextAddr <= incAddr;
                end
            end else if (sysLoad) begin
                nextAddr <= sysAddrMin;
            end

            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end

            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            addrMem[wrPtr] <= memAddrT'(curAddr);
            dataMem[wrPtr] <= sysData;
        end
        if (pop) begin
            wrAddr <= addrMem[rdPtr];
            wrData <= dataMem[rdPtr];
        end
    end

endmodule

// File: gpuDataControl.sv
/*
  Fill controller. One command writes len copies of pixel from
  xPos + yPos*HDisp onward. The command is sampled once in Idle.
  busy falls only after the buffer reports every pixel in memory,
  and a new command needs enable to drop first.
*/
`timescale 1ns/1ps

module gpuDataControl import gpuPkg::*; (
    input  logic    clk,
    input  logic    rstn,
    input  coordT   xPos,
    input  coordT   yPos,
    input  pixelT   pixel,
    input  lenT     len,
    input  logic    enable,
    output logic    busy,
    input  logic    sysValid,
    input  logic    sysIdle,
    output logic    sysLoad,
    output pixelT   sysData,
    output logic    sysWriteEnable,
    output sysAddrT sysAddrMin,
    output sysAddrT sysAddrMax
);

    fillStateT state;
    lenT       lenQ;
    lenT       wrCount;

    // Strobe follows sysValid in the same cycle
    assign sysWriteEnable = (state == Write) && (wrCount != lenQ) && sysValid;

    // Run wraps at the end of the frame
    assign sysAddrMax = sysAddrT'(FrameWords);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state   <= Idle;
            busy    <= 1'b0;
            sysLoad <= 1'b0;
            wrCount <= '0;
        end else begin
            sysLoad <= 1'b0;
            case (state)
                Idle: begin
                    wrCount <= '0;
                    if (enable) begin
                        state <= Load;
                    end
                end
                Load: begin
                    busy    <= 1'b1;
                    sysLoad <= 1'b1;
                    // Zero length skips straight to the drain wait
                    if (lenQ == '0) begin
                        state <= Flush;
                    end else begin
                        state <= Write;
                    end
                end
                Write: begin
                    if (sysWriteEnable) begin
                        wrCount <= wrCount + 1'b1;
                        if (wrCount + 1'b1 == lenQ) begin
                            state <= Flush;
                        end
                    end
                end
                Flush: begin
                    if (sysIdle) begin
                        busy  <= 1'b0;
                        state <= Done;
                    end
                end
                Done: begin
                    if (!enable) begin
                        state <= Idle;
                    end
                end
                default: begin
                    state <= Idle;
                end
            endcase
        end
    end

    // Command latch and raster start address
    always_ff @(posedge clk) begin
        if (state == Idle && enable) begin
            lenQ       <= len;
            sysData    <= pixel;
            sysAddrMin <= sysAddrT'(xPos) + sysAddrT'(yPos) * HDisp;
        end
    end

endmodule

// File: gpuFillTop.sv
/*
  Fill engine top. The host drives a fill command and reads pixels back
  over rdAddr/rdData with one cycle of latency. Reads during a fill may
  see old or new data.
*/
`timescale 1ns/1ps

module gpuFillTop import gpuPkg::*; (
    input  logic    clk,
    input  logic    rstn,
    input  coordT   xPos,
    input  coordT   yPos,
    input  pixelT   pixel,
    input  lenT     len,
    input  logic    enable,
    output logic    busy,
    input  memAddrT rdAddr,
    output pixelT   rdData
);

    logic    sysLoad;
    logic    sysWriteEnable;
    logic    sysValid;
    logic    sysIdle;
    pixelT   sysData;
    sysAddrT sysAddrMin;
    sysAddrT sysAddrMax;

    logic    wrEn;
    memAddrT wrAddr;
    pixelT   wrData;

    gpuDataControl i_gpuDataControl (
        .clk            (clk),
        .rstn           (rstn),
        .xPos           (xPos),
        .yPos           (yPos),
        .pixel          (pixel),
        .len            (len),
        .enable         (enable),
        .busy           (busy),
        .sysValid       (sysValid),
        .sysIdle        (sysIdle),
        .sysLoad        (sysLoad),
        .sysData        (sysData),
        .sysWriteEnable (sysWriteEnable),
        .sysAddrMin     (sysAddrMin),
        .sysAddrMax     (sysAddrMax)
    );

    frameWriteBuffer i_frameWriteBuffer (
        .clk            (clk),
        .rstn           (rstn),
        .sysLoad        (sysLoad),
        .sysAddrMin     (sysAddrMin),
        .sysAddrMax     (sysAddrMax),
        .sysWriteEnable (sysWriteEnable),
        .sysData        (sysData),
        .sysValid       (sysValid),
        .sysIdle        (sysIdle),
        .wrEn           (wrEn),
        .wrAddr         (wrAddr),
        .wrData         (wrData)
    );

    frameMemory i_frameMemory (
        .clk    (clk),
        .wrEn   (wrEn),
        .wrAddr (wrAddr),
        .wrData (wrData),
        .rdAddr (rdAddr),
        .rdData (rdData)
    );

endmodule

// File: gpuFillTop_props.sv
/*
  Assertions on the fill controller strobes, bound to every
  gpuDataControl instance. Checks are off while rstn is low.
*/
`timescale 1ns/1ps

module gpuFillTop_props (
    input logic clk,
    input logic rstn,
    input logic busy,
    input logic sysLoad,
    input logic sysWriteEnable,
    input logic sysValid
);

    // A strobe is only issued when the buffer has room
    writeNeedsValid: assert property (
        @(posedge clk) disable iff (!rstn) sysWriteEnable |-> sysValid
    ) else $error("sysWriteEnable high while sysValid is low");

    loadOneCycle: assert property (
        @(posedge clk) disable iff (!rstn) sysLoad |=> !sysLoad
    ) else $error("sysLoad high for more than one cycle");

    writeOnlyWhenBusy: assert property (
        @(posedge clk) disable iff (!rstn) sysWriteEnable |-> busy
    ) else $error("sysWriteEnable high while busy is low");

endmodule

bind gpuDataControl gpuFillTop_props i_gpuFillTop_props (
    .clk            (clk),
    .rstn           (rstn),
    .busy           (busy),
    .sysLoad        (sysLoad),
    .sysWriteEnable (sysWriteEnable),
    .sysValid       (sysValid)
);

// File: gpuFillTop_tb.sv
/*
  Testbench for the fill engine. Directed and random fills are checked
  against a shadow frame after each fill, by reading every word back.
  The timeout counts only cycles spent waiting for fills to finish.
*/
`timescale 1ns/1ps

module gpuFillTop_tb import gpuPkg::*; ();

    localparam int ClkPeriod     = 40;
    localparam int ResetCycles   = 3;
    localparam int RandomFills   = 20;
    localparam int MaxRandomLen  = 200;
    localparam int HoldCycles    = 20;
    // Clear fill plus random fills at two cycles per word, with margin
    localparam int TimeoutCycles = 60000;

    logic    clk;
    logic    rstn;
    coordT   xPos;
    coordT   yPos;
    pixelT   pixel;
    lenT     len;
    logic    enable;
    logic    busy;
    memAddrT rdAddr;
    pixelT   rdData;

    pixelT  shadow [FrameWords];
    integer seed       = 60767;
    int     errorCount = 0;
    int     fillCycles = 0;
    logic   filling    = 1'b0;
    logic   compareReq = 1'b0;

    gpuFillTop i_gpuFillTop (
        .clk    (clk),
        .rstn   (rstn),
        .xPos   (xPos),
        .yPos   (yPos),
        .pixel  (pixel),
        .len    (len),
        .enable (enable),
        .busy   (busy),
        .rdAddr (rdAddr),
        .rdData (rdData)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        if (filling) begin
            fillCycles = fillCycles + 1;
            if (fillCycles >= TimeoutCycles) begin
                $display("Timeout: the fills did not finish within %0d cycles", TimeoutCycles);
                $display("Some tests failed");
                $fatal(1, "Run stopped by the fill timeout");
            end
        end
    end

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            errorCount++;
            $display("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
            $display("Some tests failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Expected frame: len words in raster order, wrapping at the frame end
    function automatic void applyFill(input int x, input int y, input pixelT colour,
                                      input int count);
        int addr;
        addr = x + y * HDisp;
        for (int i = 0; i < count; i++) begin
            shadow[addr] = colour;
            addr = addr + 1;
            if (addr == FrameWords) begin
                addr = 0;
            end
        end
    endfunction

    // Pipelined read-back, one address per cycle
    initial begin : frameCompare
        forever begin
            wait (compareReq);
            for (int i = 0; i <= FrameWords; i++) begin
                @(posedge clk);
                if (i < FrameWords) begin
                    rdAddr <= memAddrT'(i);
                end
                @(negedge clk);
                if (i > 0) begin
                    checkValue($sformatf("rdData[%0d]", i - 1), rdData, shadow[i - 1]);
                end
            end
            compareReq = 1'b0;
        end
    end

    task automatic compareFrame();
        compareReq = 1'b1;
        wait (!compareReq);
    endtask

    task automatic runFill(input int x, input int y, input pixelT colour, input int count,
                           input int holdCycles);
        @(posedge clk);
        xPos   <= coordT'(x);
        yPos   <= coordT'(y);
        pixel  <= colour;
        len    <= lenT'(count);
        enable <= 1'b1;
        @(negedge clk);
        filling = 1'b1;
        while (busy !== 1'b1) begin
            @(negedge clk);
        end
        while (busy !== 1'b0) begin
            @(negedge clk);
        end
        filling = 1'b0;
        applyFill(x, y, colour, count);
        // Enable stays high with a new colour, which must not start a fill
        for (int i = 0; i < holdCycles; i++) begin
            @(posedge clk);
            pixel <= ~colour;
            @(negedge clk);
            checkValue("busy", busy, 1'b0);
        end
        @(posedge clk);
        enable <= 1'b0;
        @(posedge clk);
    endtask

    initial begin : mainSequence
        int    x;
        int    y;
        int    n;
        pixelT colour;

        rstn   = 1'b0;
        xPos   = '0;
        yPos   = '0;
        pixel  = '0;
        len    = '0;
        enable = 1'b0;
        rdAddr = '0;
        for (int i = 0; i < FrameWords; i++) begin
            shadow[i] = '0;
        end
        repeat (ResetCycles) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        checkValue("busy", busy, 1'b0);

        // Memory starts undefined, so clear the whole frame first
        runFill(0, 0, 24'h000000, FrameWords, 0);
        compareFrame();

        runFill(3, 2, 24'h12ab34, 10, 0);
        compareFrame();

        // Starts four words before the frame end
        runFill(HDisp - 4, VDisp - 1, 24'h5a3c96, 10, 0);
        compareFrame();

        runFill(7, 9, 24'hffffff, 0, 0);
        compareFrame();

        runFill(20, 30, 24'h0f0f0f, 25, HoldCycles);
        runFill(21, 31, 24'h707070, 5, 0);
        compareFrame();

        for (int k = 0; k < RandomFills; k++) begin
            x      = $unsigned($random(seed)) % HDisp;
            y      = $unsigned($random(seed)) % VDisp;
            colour = pixelT'($random(seed));
            n      = $unsigned($random(seed)) % (MaxRandomLen + 1);
            runFill(x, y, colour, n, 0);
            compareFrame();
        end

        if (errorCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: gpuFillTop.f
gpuPkg.sv
frameMemory.sv
frameWriteBuffer.sv
gpuDataControl.sv
gpuFillTop.sv
gpuFillTop_props.sv
gpuFillTop_tb.sv

// File: Bender.yml
package:
  name: gpu_fill

sources:
  - files:
      - gpuPkg.sv
      - frameMemory.sv
      - frameWriteBuffer.sv
      - gpuDataControl.sv
      - gpuFillTop.sv
  - target: simulation
    files:
      - gpuFillTop_props.sv
      - gpuFillTop_tb.sv
